//--- all.f
+incdir+verilog
verilog/axil_pkg.sv
verilog/axil_if.sv
verilog/axil_1x2_crossbar.sv
verilog/axil_reg_bank.sv
verilog/axil_mailbox.sv
verilog/axil_mmio_top.sv
verification/axil_mmio_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f all.f \
    --top-module axil_mmio_tb -o axil_mmio_sim
./obj_dir/axil_mmio_sim | tee sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- verification/axil_mmio_tb.sv
`default_nettype none

`include "mmio_params.svh"

module axil_mmio_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int RANDOM_OPS     = 400;

    logic            clk = 1'b0;
    logic            rst;
    logic            s_axil_awvalid;
    logic            s_axil_awready;
    axil_pkg::addr_t s_axil_awaddr;
    axil_pkg::prot_t s_axil_awprot;
    logic            s_axil_wvalid;
    logic            s_axil_wready;
    axil_pkg::data_t s_axil_wdata;
    axil_pkg::strb_t s_axil_wstrb;
    logic            s_axil_bvalid;
    logic            s_axil_bready;
    axil_pkg::resp_t s_axil_bresp;
    logic            s_axil_arvalid;
    logic            s_axil_arready;
    axil_pkg::addr_t s_axil_araddr;
    axil_pkg::prot_t s_axil_arprot;
    logic            s_axil_rvalid;
    logic            s_axil_rready;
    axil_pkg::data_t s_axil_rdata;
    axil_pkg::resp_t s_axil_rresp;

    logic [31:0]     rand_state;
    axil_pkg::data_t model_regs [`REG_COUNT];
    axil_pkg::data_t model_fifo [$];

    axil_mmio_top dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state ^ (rand_state >> 15);
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping after a timeout");
    endtask

    function automatic logic in_window(input axil_pkg::addr_t a);
        return (a >= `S0_BASE) && (a < `S0_BASE + `S0_SIZE);
    endfunction

    function automatic axil_pkg::data_t merge_bytes(input axil_pkg::data_t old_val,
                                                    input axil_pkg::data_t new_val,
                                                    input axil_pkg::strb_t strb);
        axil_pkg::data_t result;
        result = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Random address inside the window, upper bits alias onto the same register
    function automatic axil_pkg::addr_t reg_addr(input logic [2:0] idx);
        return `S0_BASE | (next_rand() & 32'h0FFF_FFE0) | (axil_pkg::addr_t'(idx) << 2);
    endfunction

    function automatic axil_pkg::addr_t mbox_addr(input logic count_word);
        axil_pkg::addr_t a;
        a = next_rand() & 32'hFFFF_FFF8;
        if (in_window(a)) begin
            a = a ^ 32'h2000_0000;
        end
        a[2] = count_word;
        return a;
    endfunction

    task automatic write_and_check(input string name, input axil_pkg::addr_t addr,
                                   input axil_pkg::data_t data, input axil_pkg::strb_t strb);
        int              wait_n;
        int              stall;
        axil_pkg::resp_t resp;
        axil_pkg::resp_t exp_resp;
        @(negedge clk);
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_awaddr  = addr;
        s_axil_awprot  = axil_pkg::prot_t'(next_rand());
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        wait_n = 0;
        #1;
        while (!(s_axil_awready && s_axil_wready)) begin
            wait_n++;
            if (wait_n > TIMEOUT_CYCLES) report_timeout("write request was never accepted");
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        wait_n = 0;
        #1;
        while (!s_axil_bvalid) begin
            wait_n++;
            if (wait_n > TIMEOUT_CYCLES) report_timeout("write response never arrived");
            @(negedge clk);
            #1;
        end
        resp  = s_axil_bresp;
        stall = int'(next_rand() % 32'd4);
        repeat (stall) begin
            @(negedge clk);
            #1;
            check_equal({name, " stalled bvalid"}, 32'd1, 32'(s_axil_bvalid));
            check_equal({name, " stalled bresp"}, 32'(resp), 32'(s_axil_bresp));
        end
        @(negedge clk);
        s_axil_bready = 1'b1;
        @(negedge clk);
        s_axil_bready = 1'b0;
        exp_resp = axil_pkg::RESP_OKAY;
        if (in_window(addr)) begin
            model_regs[addr[4:2]] = merge_bytes(model_regs[addr[4:2]], data, strb);
        end else if (!addr[2]) begin
            // A push into a full mailbox is dropped
            if (model_fifo.size() >= `MAILBOX_DEPTH) begin
                exp_resp = axil_pkg::RESP_SLVERR;
            end else begin
                model_fifo.push_back(data);
            end
        end
        check_equal({name, " bresp"}, 32'(exp_resp), 32'(resp));
    endtask

    task automatic read_and_check(input string name, input axil_pkg::addr_t addr);
        int              wait_n;
        int              stall;
        axil_pkg::data_t data;
        axil_pkg::resp_t resp;
        axil_pkg::data_t exp_data;
        axil_pkg::resp_t exp_resp;
        @(negedge clk);
        s_axil_arvalid = 1'b1;
        s_axil_araddr  = addr;
        s_axil_arprot  = axil_pkg::prot_t'(next_rand());
        wait_n = 0;
        #1;
        while (!s_axil_arready) begin
            wait_n++;
            if (wait_n > TIMEOUT_CYCLES) report_timeout("read request was never accepted");
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        wait_n = 0;
        #1;
        while (!s_axil_rvalid) begin
            wait_n++;
            if (wait_n > TIMEOUT_CYCLES) report_timeout("read response never arrived");
            @(negedge clk);
            #1;
        end
        data  = s_axil_rdata;
        resp  = s_axil_rresp;
        stall = int'(next_rand() % 32'd4);
        repeat (stall) begin
            @(negedge clk);
            #1;
            check_equal({name, " stalled rvalid"}, 32'd1, 32'(s_axil_rvalid));
            check_equal({name, " stalled rdata"}, data, s_axil_rdata);
            check_equal({name, " stalled rresp"}, 32'(resp), 32'(s_axil_rresp));
        end
        @(negedge clk);
        s_axil_rready = 1'b1;
        @(negedge clk);
        s_axil_rready = 1'b0;
        exp_resp = axil_pkg::RESP_OKAY;
        if (in_window(addr)) begin
            exp_data = model_regs[addr[4:2]];
        end else if (addr[2]) begin
            exp_data = axil_pkg::data_t'(model_fifo.size());
        end else if (model_fifo.size() == 0) begin
            exp_data = '0;
            exp_resp = axil_pkg::RESP_SLVERR;
        end else begin
            exp_data = model_fifo.pop_front();
        end
        check_equal({name, " rdata"}, exp_data, data);
        check_equal({name, " rresp"}, 32'(exp_resp), 32'(resp));
    endtask

    initial begin
        logic [31:0] r;
        rand_state     = 32'h7d11;
        rst            = 1'b1;
        s_axil_awvalid = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awprot  = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_bready  = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arprot  = '0;
        s_axil_rready  = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < `REG_COUNT; i++) begin
            read_and_check("reset register", reg_addr(3'(i)));
        end
        read_and_check("reset count", 32'h0000_0004);

        repeat (40) begin
            write_and_check("register write", reg_addr(3'(next_rand())), next_rand(),
                            axil_pkg::strb_t'(next_rand()));
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            read_and_check("register readback", reg_addr(3'(i)));
        end

        // Both sides of the window edges route to the mailbox
        write_and_check("push at zero", 32'h0000_0000, 32'hA5A5_0001, 4'hF);
        write_and_check("push at window end", 32'h2000_0000, 32'hA5A5_0002, 4'h0);
        read_and_check("count below window", 32'h0FFF_FFFC);
        read_and_check("pop at window end", 32'h2000_0000);
        read_and_check("pop at zero", 32'h0000_0000);
        read_and_check("count at top", 32'hFFFF_FFFC);

        for (int i = 0; i <= `MAILBOX_DEPTH; i++) begin
            write_and_check("mailbox fill", mbox_addr(1'b0), next_rand(), 4'hF);
        end
        read_and_check("mailbox full count", mbox_addr(1'b1));
        for (int i = 0; i <= `MAILBOX_DEPTH; i++) begin
            read_and_check("mailbox drain", mbox_addr(1'b0));
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_rand();
            case (r[1:0])
                2'd0: write_and_check("random register write", reg_addr(r[4:2]), next_rand(),
                                      axil_pkg::strb_t'(next_rand()));
                2'd1: read_and_check("random register read", reg_addr(r[4:2]));
                2'd2: write_and_check("random mailbox write", mbox_addr(r[5] & r[6]),
                                      next_rand(), axil_pkg::strb_t'(next_rand()));
                default: read_and_check("random mailbox read", mbox_addr(r[7] & r[8]));
            endcase
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/axil_1x2_crossbar.sv
`default_nettype none

`include "mmio_params.svh"

module axil_1x2_crossbar (
    input  logic clk,
    input  logic rst,
    axil_if.subordinate host,
    axil_if.manager     s0,
    axil_if.manager     s1
);

    logic rd_in_s0;
    logic wr_in_s0;
    logic rd_pend;
    logic wr_pend;
    // Owner flags are high when the mailbox side holds the transaction
    logic rd_owner_s1;
    logic wr_owner_s1;

    assign rd_in_s0 = (host.araddr >= `S0_BASE) && (host.araddr < (`S0_BASE + `S0_SIZE));
    assign wr_in_s0 = (host.awaddr >= `S0_BASE) && (host.awaddr < (`S0_BASE + `S0_SIZE));

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend     <= 1'b0;
            rd_owner_s1 <= 1'b0;
        end else if (host.arvalid && host.arready) begin
            rd_pend     <= 1'b1;
            rd_owner_s1 <= !rd_in_s0;
        end else if (host.rvalid && host.rready) begin
            rd_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pend     <= 1'b0;
            wr_owner_s1 <= 1'b0;
        end else if (host.awvalid && host.awready) begin
            wr_pend     <= 1'b1;
            wr_owner_s1 <= !wr_in_s0;
        end else if (host.bvalid && host.bready) begin
            wr_pend <= 1'b0;
        end
    end

    // Requests are held off while a response of the same direction is open
    assign s0.arvalid   = host.arvalid && rd_in_s0 && !rd_pend;
    assign s1.arvalid   = host.arvalid && !rd_in_s0 && !rd_pend;
    assign host.arready = !rd_pend && (rd_in_s0 ? s0.arready : s1.arready);
    assign s0.araddr    = host.araddr;
    assign s1.araddr    = host.araddr;
    assign s0.arprot    = host.arprot;
    assign s1.arprot    = host.arprot;

    assign s0.awvalid   = host.awvalid && wr_in_s0 && !wr_pend;
    assign s1.awvalid   = host.awvalid && !wr_in_s0 && !wr_pend;
    assign host.awready = !wr_pend && (wr_in_s0 ? s0.awready : s1.awready);
    assign s0.awaddr    = host.awaddr;
    assign s1.awaddr    = host.awaddr;
    assign s0.awprot    = host.awprot;
    assign s1.awprot    = host.awprot;

    assign s0.wvalid    = host.wvalid && wr_in_s0 && !wr_pend;
    assign s1.wvalid    = host.wvalid && !wr_in_s0 && !wr_pend;
    assign host.wready  = !wr_pend && (wr_in_s0 ? s0.wready : s1.wready);
    assign s0.wdata     = host.wdata;
    assign s1.wdata     = host.wdata;
    assign s0.wstrb     = host.wstrb;
    assign s1.wstrb     = host.wstrb;

    assign host.rvalid  = rd_owner_s1 ? s1.rvalid : s0.rvalid;
    assign host.rdata   = rd_owner_s1 ? s1.rdata : s0.rdata;
    assign host.rresp   = rd_owner_s1 ? s1.rresp : s0.rresp;
    assign s0.rready    = host.rready && !rd_owner_s1;
    assign s1.rready    = host.rready && rd_owner_s1;

    assign host.bvalid  = wr_owner_s1 ? s1.bvalid : s0.bvalid;
    assign host.bresp   = wr_owner_s1 ? s1.bresp : s0.bresp;
    assign s0.bready    = host.bready && !wr_owner_s1;
    assign s1.bready    = host.bready && wr_owner_s1;

endmodule

`default_nettype wire

//--- verilog/axil_if.sv
`default_nettype none

interface axil_if;

    logic            awvalid;
    logic            awready;
    axil_pkg::addr_t awaddr;
    axil_pkg::prot_t awprot;

    logic            wvalid;
    logic            wready;
    axil_pkg::data_t wdata;
    axil_pkg::strb_t wstrb;

    logic            bvalid;
    logic            bready;
    axil_pkg::resp_t bresp;

    logic            arvalid;
    logic            arready;
    axil_pkg::addr_t araddr;
    axil_pkg::prot_t arprot;

    logic            rvalid;
    logic            rready;
    axil_pkg::data_t rdata;
    axil_pkg::resp_t rresp;

    modport manager (
        output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arprot, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport subordinate (
        input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, arprot, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

//--- verilog/axil_mailbox.sv
`default_nettype none

`include "mmio_params.svh"

module axil_mailbox (
    input  logic clk,
    input  logic rst,
    axil_if.subordinate bus
);

    localparam int PTR_W = $clog2(`MAILBOX_DEPTH);
    localparam int CNT_W = $clog2(`MAILBOX_DEPTH + 1);

    axil_pkg::data_t  fifo_mem [`MAILBOX_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             empty;
    logic             wr_fire;
    logic             rd_fire;
    logic             push;
    logic             pop;

    assign full  = (count == CNT_W'(`MAILBOX_DEPTH));
    assign empty = (count == '0);

    assign wr_fire     = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign bus.awready = wr_fire;
    assign bus.wready  = wr_fire;
    assign bus.arready = !bus.rvalid;
    assign rd_fire     = bus.arvalid && !bus.rvalid;

    // Address bit 2 selects the count word when set and the data word when clear
    assign push = wr_fire && !bus.awaddr[2] && !full;
    assign pop  = rd_fire && !bus.araddr[2] && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`MAILBOX_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`MAILBOX_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bready) begin
                bus.bvalid <= 1'b0;
            end
            if (rd_fire) begin
                bus.rvalid <= 1'b1;
            end else if (bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            // A push into a full FIFO is dropped and flagged
            bus.bresp <= (!bus.awaddr[2] && full) ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
        end
        if (rd_fire) begin
            if (bus.araddr[2]) begin
                bus.rdata <= axil_pkg::data_t'(count);
                bus.rresp <= axil_pkg::RESP_OKAY;
            end else if (empty) begin
                bus.rdata <= '0;
                bus.rresp <= axil_pkg::RESP_SLVERR;
            end else begin
                bus.rdata <= fifo_mem[rd_ptr];
                bus.rresp <= axil_pkg::RESP_OKAY;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/axil_mmio_top.sv
`default_nettype none

module axil_mmio_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            s_axil_awvalid,
    output logic            s_axil_awready,
    input  axil_pkg::addr_t s_axil_awaddr,
    input  axil_pkg::prot_t s_axil_awprot,
    input  logic            s_axil_wvalid,
    output logic            s_axil_wready,
    input  axil_pkg::data_t s_axil_wdata,
    input  axil_pkg::strb_t s_axil_wstrb,
    output logic            s_axil_bvalid,
    input  logic            s_axil_bready,
    output axil_pkg::resp_t s_axil_bresp,
    input  logic            s_axil_arvalid,
    output logic            s_axil_arready,
    input  axil_pkg::addr_t s_axil_araddr,
    input  axil_pkg::prot_t s_axil_arprot,
    output logic            s_axil_rvalid,
    input  logic            s_axil_rready,
    output axil_pkg::data_t s_axil_rdata,
    output axil_pkg::resp_t s_axil_rresp
);

    // Host side bundle feeding the crossbar from the plain ports
    axil_if bus_host ();
    axil_if bus_regs ();
    axil_if bus_mbox ();

    assign bus_host.awvalid = s_axil_awvalid;
    assign bus_host.awaddr  = s_axil_awaddr;
    assign bus_host.awprot  = s_axil_awprot;
    assign bus_host.wvalid  = s_axil_wvalid;
    assign bus_host.wdata   = s_axil_wdata;
    assign bus_host.wstrb   = s_axil_wstrb;
    assign bus_host.bready  = s_axil_bready;
    assign bus_host.arvalid = s_axil_arvalid;
    assign bus_host.araddr  = s_axil_araddr;
    assign bus_host.arprot  = s_axil_arprot;
    assign bus_host.rready  = s_axil_rready;

    assign s_axil_awready = bus_host.awready;
    assign s_axil_wready  = bus_host.wready;
    assign s_axil_bvalid  = bus_host.bvalid;
    assign s_axil_bresp   = bus_host.bresp;
    assign s_axil_arready = bus_host.arready;
    assign s_axil_rvalid  = bus_host.rvalid;
    assign s_axil_rdata   = bus_host.rdata;
    assign s_axil_rresp   = bus_host.rresp;

    axil_1x2_crossbar u_crossbar (
        .clk  (clk),
        .rst  (rst),
        .host (bus_host.subordinate),
        .s0   (bus_regs.manager),
        .s1   (bus_mbox.manager)
    );

    axil_reg_bank u_reg_bank (
        .clk (clk),
        .rst (rst),
        .bus (bus_regs.subordinate)
    );

    axil_mailbox u_mailbox (
        .clk (clk),
        .rst (rst),
        .bus (bus_mbox.subordinate)
    );

endmodule

`default_nettype wire

//--- verilog/axil_pkg.sv
`default_nettype none

`include "mmio_params.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_W-1:0]   addr_t;
    typedef logic [`AXIL_DATA_W-1:0]   data_t;
    typedef logic [`AXIL_DATA_W/8-1:0] strb_t;
    typedef logic [2:0]                prot_t;
    typedef logic [1:0]                resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- verilog/axil_reg_bank.sv
`default_nettype none

`include "mmio_params.svh"

module axil_reg_bank (
    input  logic clk,
    input  logic rst,
    axil_if.subordinate bus
);

    localparam int IDX_W  = $clog2(`REG_COUNT);
    localparam int BYTE_N = `AXIL_DATA_W / 8;

    axil_pkg::data_t  regs [`REG_COUNT];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_fire;
    logic             rd_fire;

    // Word index sits just above the byte offset, upper bits alias
    assign wr_idx = bus.awaddr[IDX_W+1:2];
    assign rd_idx = bus.araddr[IDX_W+1:2];

    // AW and W are taken in the same cycle once both are offered
    assign wr_fire     = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign bus.awready = wr_fire;
    assign bus.wready  = wr_fire;
    assign bus.arready = !bus.rvalid;
    assign rd_fire     = bus.arvalid && !bus.rvalid;

    assign bus.bresp = axil_pkg::RESP_OKAY;
    assign bus.rresp = axil_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire) begin
            for (int b = 0; b < BYTE_N; b++) begin
                if (bus.wstrb[b]) begin
                    regs[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bus.bvalid <= 1'b1;
            end else if (bus.bready) begin
                bus.bvalid <= 1'b0;
            end
            if (rd_fire) begin
                bus.rvalid <= 1'b1;
            end else if (bus.rready) begin
                bus.rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            bus.rdata <= regs[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/mmio_params.svh
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Bus widths of the AXI4-Lite fabric
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Register window, the end address is excluded
`define S0_BASE 32'h1000_0000
`define S0_SIZE 32'h1000_0000

// Register bank and mailbox sizes
`define REG_COUNT 8
`define MAILBOX_DEPTH 4

`endif
